// File: rtl/img_pkg.sv
package img_pkg;

    // ==========================================================
    // Stored image format
    // ==========================================================
    localparam int pixel_w      = 12;
    localparam int word_w       = 16;
    localparam int header_words = 8;
    localparam int header_w     = header_words * word_w;
    // High pixel bits looked at for highlight and shadow counts
    localparam int stat_bits    = 7;

    // ==========================================================
    // On-chip RAM and readout buffer
    // ==========================================================
    localparam int block_words = 1024;
    localparam int block_count = 2;
    localparam int fifo_depth  = 8;

    typedef logic [pixel_w-1:0] pixel_t;
    typedef logic [word_w-1:0] word_t;
    // Word 0 is the top 16 bits
    typedef logic [header_w-1:0] header_t;
    typedef logic [$clog2(block_words+1)-1:0] word_count_t;
    typedef logic [$clog2(block_words)-1:0] word_addr_t;
    typedef logic [$clog2(block_count)-1:0] block_sel_t;
    typedef logic [17:0] stat_count_t;

endpackage

// File: rtl/ctrl_pkg.sv
package ctrl_pkg;

    // Host commands
    typedef enum logic {
        CMD_CAPTURE,
        CMD_READOUT
    } img_cmd_t;

    // Top level command FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CAPTURE,
        ST_READOUT,
        ST_ACK
    } ctrl_state_t;

    // Pixel capture FSM
    typedef enum logic [2:0] {
        CAP_IDLE,
        CAP_HEADER,
        CAP_WAIT_INVALID,
        CAP_WAIT_FRAME,
        CAP_PIXELS,
        CAP_SUM_HI,
        CAP_SUM_LO
    } capture_state_t;

endpackage

// File: rtl/fletcher_checksum.sv
`timescale 1ns/1ps

module fletcher_checksum
    import img_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clear,
    input  logic        en,
    input  word_t       din,
    output logic [31:0] sum
);

    logic [15:0] sum1;
    logic [15:0] sum2;
    logic [16:0] add1;
    logic [16:0] add2;
    logic [15:0] next1;
    logic [15:0] next2;

    // Both sums stay below 65535, so a single subtraction folds them back
    always_comb begin
        add1  = {1'b0, sum1} + {1'b0, din};
        next1 = (add1 >= 17'd65535) ? 16'(add1 - 17'd65535) : add1[15:0];
        add2  = {1'b0, sum2} + {1'b0, next1};
        next2 = (add2 >= 17'd65535) ? 16'(add2 - 17'd65535) : add2[15:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum1 <= '0;
            sum2 <= '0;
        end else if (clear) begin
            sum1 <= '0;
            sum2 <= '0;
        end else if (en) begin
            sum1 <= next1;
            sum2 <= next2;
        end
    end

    assign sum = {sum2, sum1};

    // A new image never starts while a word is still being summed
    a_clear_en: assert property (@(posedge clk) disable iff (!rst_n)
        !(clear && en));

endmodule

// File: rtl/pixel_capture.sv
`timescale 1ns/1ps

module pixel_capture
    import img_pkg::*;
    import ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        capture_start,
    input  header_t     header,
    input  pixel_t      pix_d,
    input  logic        pix_fv,
    input  logic        pix_lv,
    output logic        wr_valid,
    output word_t       wr_data,
    output logic        capture_done,
    output stat_count_t highlight_count,
    output stat_count_t shadow_count
);

    typedef logic [$clog2(header_words)-1:0] hdr_idx_t;

    capture_state_t state;
    pixel_t         pix_q;
    logic           fv_q;
    logic           lv_q;
    logic           lv_prev;
    header_t        hdr_shift;
    hdr_idx_t       hdr_left;
    logic [1:0]     col;
    logic [1:0]     row;
    logic           sum_en;
    logic           sum_lo_sent;
    logic [31:0]    sum;
    logic           frame_px;
    logic           grid_px;
    logic [stat_bits-1:0] px_top;

    // ==========================================================
    // Input register
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fv_q    <= 1'b0;
            lv_q    <= 1'b0;
            lv_prev <= 1'b0;
        end else begin
            fv_q    <= pix_fv;
            lv_q    <= pix_lv;
            lv_prev <= lv_q;
        end
    end

    always_ff @(posedge clk) begin
        pix_q <= pix_d;
    end

    // Pixel in pix_q belongs to the frame being stored
    assign frame_px = fv_q && lv_q && (state == CAP_WAIT_FRAME || state == CAP_PIXELS);

    // Position on the 4x4 sampling grid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= 2'd0;
            row <= 2'd0;
        end else begin
            col <= lv_q ? col + 2'd1 : 2'd0;
            if (!fv_q) begin
                row <= 2'd0;
            end else if (lv_prev && !lv_q) begin
                row <= row + 2'd1;
            end
        end
    end

    assign grid_px = frame_px && col == 2'd0 && row == 2'd0;
    assign px_top  = pix_q[pixel_w-1 -: stat_bits];

    // ==========================================================
    // Capture FSM
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= CAP_IDLE;
            wr_valid     <= 1'b0;
            sum_en       <= 1'b0;
            sum_lo_sent  <= 1'b0;
            capture_done <= 1'b0;
            hdr_left     <= '0;
        end else begin
            // Pixels only qualify in the frame states
            wr_valid     <= frame_px;
            sum_en       <= frame_px;
            sum_lo_sent  <= 1'b0;
            capture_done <= sum_lo_sent;
            case (state)
                CAP_IDLE: begin
                    if (capture_start) begin
                        wr_valid <= 1'b1;
                        sum_en   <= 1'b1;
                        hdr_left <= hdr_idx_t'(header_words - 1);
                        state    <= CAP_HEADER;
                    end
                end
                CAP_HEADER: begin
                    wr_valid <= 1'b1;
                    sum_en   <= 1'b1;
                    hdr_left <= hdr_left - hdr_idx_t'(1);
                    if (hdr_left == hdr_idx_t'(1)) begin
                        state <= CAP_WAIT_INVALID;
                    end
                end
                // Skip the rest of a frame already in progress
                CAP_WAIT_INVALID: begin
                    if (!fv_q) begin
                        state <= CAP_WAIT_FRAME;
                    end
                end
                CAP_WAIT_FRAME: begin
                    if (fv_q) begin
                        state <= CAP_PIXELS;
                    end
                end
                CAP_PIXELS: begin
                    if (!fv_q) begin
                        state <= CAP_SUM_HI;
                    end
                end
                CAP_SUM_HI: begin
                    wr_valid <= 1'b1;
                    state    <= CAP_SUM_LO;
                end
                CAP_SUM_LO: begin
                    wr_valid    <= 1'b1;
                    sum_lo_sent <= 1'b1;
                    state       <= CAP_IDLE;
                end
                default: state <= CAP_IDLE;
            endcase
        end
    end

    // Output word register
    always_ff @(posedge clk) begin
        case (state)
            CAP_IDLE: begin
                if (capture_start) begin
                    wr_data   <= header[header_w-1 -: word_w];
                    hdr_shift <= header << word_w;
                end
            end
            CAP_HEADER: begin
                wr_data   <= hdr_shift[header_w-1 -: word_w];
                hdr_shift <= hdr_shift << word_w;
            end
            CAP_SUM_HI: wr_data <= sum[31:16];
            CAP_SUM_LO: wr_data <= sum[15:0];
            default: begin
                if (frame_px) begin
                    wr_data <= {{(word_w - pixel_w){1'b0}}, pix_q};
                end
            end
        endcase
    end

    // Checksum covers header and pixel words, not its own two words
    fletcher_checksum u_checksum (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (capture_start),
        .en    (sum_en),
        .din   (wr_data),
        .sum   (sum)
    );

    // ==========================================================
    // Highlight and shadow statistics
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            highlight_count <= '0;
            shadow_count    <= '0;
        end else if (capture_start) begin
            highlight_count <= '0;
            shadow_count    <= '0;
        end else if (grid_px) begin
            if (&px_top) begin
                highlight_count <= highlight_count + 1'b1;
            end else if (~|px_top) begin
                shadow_count <= shadow_count + 1'b1;
            end
        end
    end

    // The top only starts a capture once the previous one has finished
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        capture_start |-> state == CAP_IDLE);

endmodule

// File: rtl/image_ram.sv
`timescale 1ns/1ps

module image_ram
    import img_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  block_sel_t  block,
    input  logic        wr_restart,
    input  logic        wr_valid,
    input  word_t       wr_data,
    output word_count_t wr_count,
    input  logic        rd_restart,
    input  logic        rd_room,
    output logic        rd_valid,
    output word_t       rd_data,
    output logic        rd_done
);

    word_t       mem [block_count][block_words];
    word_count_t blk_len [block_count];
    block_sel_t  blk;
    word_count_t rd_ptr;
    logic        rd_active;
    logic        rd_left;
    logic        rd_issue;

    assign rd_left  = rd_ptr != blk_len[blk];
    assign rd_issue = rd_active && rd_room && rd_left;

    // ==========================================================
    // Block select, lengths and read sequencing
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blk       <= '0;
            wr_count  <= '0;
            rd_ptr    <= '0;
            rd_active <= 1'b0;
            rd_valid  <= 1'b0;
            rd_done   <= 1'b0;
            for (int i = 0; i < block_count; i++) begin
                blk_len[i] <= '0;
            end
        end else begin
            rd_valid <= rd_issue;
            if (wr_restart) begin
                blk           <= block;
                wr_count      <= '0;
                blk_len[block] <= '0;
            end else if (wr_valid && wr_count != word_count_t'(block_words)) begin
                wr_count     <= wr_count + 1'b1;
                blk_len[blk] <= wr_count + 1'b1;
            end
            if (rd_restart) begin
                blk       <= block;
                rd_ptr    <= '0;
                rd_active <= 1'b1;
                rd_done   <= 1'b0;
            end else if (rd_active) begin
                if (rd_issue) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                if (!rd_left) begin
                    rd_active <= 1'b0;
                    rd_done   <= 1'b1;
                end
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (wr_valid && !wr_restart) begin
            mem[blk][word_addr_t'(wr_count)] <= wr_data;
        end
        if (rd_issue) begin
            rd_data <= mem[blk][word_addr_t'(rd_ptr)];
        end
    end

    // Image size must fit in one block
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        wr_valid |-> wr_count != word_count_t'(block_words));

endmodule

// File: rtl/word_fifo.sv
`timescale 1ns/1ps

module word_fifo
    import img_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  flush,
    input  logic  push,
    input  word_t push_data,
    output logic  room,
    output logic  pop_valid,
    input  logic  pop_ready,
    output word_t pop_data
);

    word_t                           mem [fifo_depth];
    logic [$clog2(fifo_depth)-1:0]   wr_ptr;
    logic [$clog2(fifo_depth)-1:0]   rd_ptr;
    logic [$clog2(fifo_depth):0]     count;
    logic                            pop;

    assign pop       = pop_valid && pop_ready;
    assign pop_valid = count != '0;
    assign pop_data  = mem[rd_ptr];
    // Two free slots leave space for the read already in flight
    assign room      = count <= ($clog2(fifo_depth) + 1)'(fifo_depth - 2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // RAM reads are throttled by room, so the buffer never overflows
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> count != ($clog2(fifo_depth) + 1)'(fifo_depth));

endmodule

// File: rtl/img_controller.sv
`timescale 1ns/1ps

module img_controller
    import img_pkg::*;
    import ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cmd_req,
    input  img_cmd_t    cmd_op,
    input  block_sel_t  cmd_block,
    input  header_t     cmd_header,
    output logic        cmd_ack,
    input  pixel_t      pix_d,
    input  logic        pix_fv,
    input  logic        pix_lv,
    output logic        readout_valid,
    input  logic        readout_ready,
    output word_t       readout_data,
    output word_count_t status_word_count,
    output stat_count_t status_highlight_count,
    output stat_count_t status_shadow_count
);

    ctrl_state_t state;
    logic        capture_start;
    logic        rd_restart;
    word_count_t remaining;
    word_count_t blk_len [block_count];
    logic        xfer;

    logic        wr_valid;
    word_t       wr_data;
    word_count_t wr_count;
    logic        capture_done;
    logic        rd_valid;
    word_t       rd_data;
    logic        rd_done;
    logic        rd_room;

    assign xfer = readout_valid && readout_ready;

    // Capture results hold until the next capture clears them
    assign status_word_count = wr_count;

    // ==========================================================
    // Command FSM
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            cmd_ack       <= 1'b0;
            capture_start <= 1'b0;
            rd_restart    <= 1'b0;
            remaining     <= '0;
            for (int i = 0; i < block_count; i++) begin
                blk_len[i] <= '0;
            end
        end else begin
            capture_start <= 1'b0;
            rd_restart    <= 1'b0;
            if (xfer) begin
                remaining <= remaining - 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (cmd_req) begin
                        if (cmd_op == CMD_CAPTURE) begin
                            capture_start <= 1'b1;
                            state         <= ST_CAPTURE;
                        end else begin
                            rd_restart <= 1'b1;
                            remaining  <= blk_len[cmd_block];
                            state      <= ST_READOUT;
                        end
                    end
                end
                ST_CAPTURE: begin
                    if (capture_done) begin
                        blk_len[cmd_block] <= wr_count;
                        cmd_ack            <= 1'b1;
                        state              <= ST_ACK;
                    end
                end
                // Done on the cycle the last word leaves the port
                ST_READOUT: begin
                    if (remaining == '0 || (xfer && remaining == word_count_t'(1))) begin
                        cmd_ack <= 1'b1;
                        state   <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ==========================================================
    // Datapath
    // ==========================================================
    pixel_capture u_capture (
        .clk             (clk),
        .rst_n           (rst_n),
        .capture_start   (capture_start),
        .header          (cmd_header),
        .pix_d           (pix_d),
        .pix_fv          (pix_fv),
        .pix_lv          (pix_lv),
        .wr_valid        (wr_valid),
        .wr_data         (wr_data),
        .capture_done    (capture_done),
        .highlight_count (status_highlight_count),
        .shadow_count    (status_shadow_count)
    );

    // Write side restarts together with the capture
    image_ram u_ram (
        .clk        (clk),
        .rst_n      (rst_n),
        .block      (cmd_block),
        .wr_restart (capture_start),
        .wr_valid   (wr_valid),
        .wr_data    (wr_data),
        .wr_count   (wr_count),
        .rd_restart (rd_restart),
        .rd_room    (rd_room),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .rd_done    (rd_done)
    );

    word_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (rd_restart),
        .push      (rd_valid),
        .push_data (rd_data),
        .room      (rd_room),
        .pop_valid (readout_valid),
        .pop_ready (readout_ready),
        .pop_data  (readout_data)
    );

    // The port never delivers more words than the block holds
    a_no_extra_word: assert property (@(posedge clk) disable iff (!rst_n)
        xfer |-> state == ST_READOUT && remaining != '0);

    // By the last transfer the RAM has issued every read of the block
    a_reads_issued: assert property (@(posedge clk) disable iff (!rst_n)
        (xfer && remaining == word_count_t'(1)) |-> rd_done);

endmodule

// File: verification/img_controller_tb.sv
`timescale 1ns/1ps

module img_controller_tb
    import img_pkg::*;
    import ctrl_pkg::*;
();

    // One row per captured image
    typedef struct packed {
        block_sel_t blk;
        logic [7:0] width;
        logic [7:0] height;
        logic [3:0] idle_lines;
        logic       mid_frame;
        logic       gaps;
        word_t      seed;
    } frame_row_t;

    localparam int frame_rows      = 4;
    localparam int line_blank      = 4;
    localparam int ack_timeout     = 100;
    localparam int readout_timeout = 2000;

    logic        clk;
    logic        rst_n;
    logic        cmd_req;
    img_cmd_t    cmd_op;
    block_sel_t  cmd_block;
    header_t     cmd_header;
    logic        cmd_ack;
    pixel_t      pix_d;
    logic        pix_fv;
    logic        pix_lv;
    logic        readout_valid;
    logic        readout_ready;
    word_t       readout_data;
    word_count_t status_word_count;
    stat_count_t status_highlight_count;
    stat_count_t status_shadow_count;

    frame_row_t  frames [frame_rows];
    logic [31:0] lfsr;
    word_t       exp_mem [block_count][block_words];
    int          exp_len [block_count];
    stat_count_t exp_highlight;
    stat_count_t exp_shadow;

    img_controller DUT (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .cmd_req                (cmd_req),
        .cmd_op                 (cmd_op),
        .cmd_block              (cmd_block),
        .cmd_header             (cmd_header),
        .cmd_ack                (cmd_ack),
        .pix_d                  (pix_d),
        .pix_fv                 (pix_fv),
        .pix_lv                 (pix_lv),
        .readout_valid          (readout_valid),
        .readout_ready          (readout_ready),
        .readout_data           (readout_data),
        .status_word_count      (status_word_count),
        .status_highlight_count (status_highlight_count),
        .status_shadow_count    (status_shadow_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==========================================================
    // Random source and reference model
    // ==========================================================
    // Taps 32, 22, 2, 1
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] lfsr_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic pixel_t next_pixel();
        pixel_t     p;
        logic [1:0] kind;
        p    = pixel_t'(lfsr_bits(pixel_w));
        kind = 2'(lfsr_bits(2));
        // Force about half the pixels into highlight or shadow range
        if (kind == 2'd0) begin
            p[pixel_w-1 -: stat_bits] = '1;
        end else if (kind == 2'd1) begin
            p[pixel_w-1 -: stat_bits] = '0;
        end
        return p;
    endfunction

    function automatic logic [31:0] fletcher32(block_sel_t b, int n);
        int s1;
        int s2;
        s1 = 0;
        s2 = 0;
        for (int i = 0; i < n; i++) begin
            s1 = (s1 + int'(exp_mem[b][i])) % 65535;
            s2 = (s2 + s1) % 65535;
        end
        return {s2[15:0], s1[15:0]};
    endfunction

    task automatic store_word(block_sel_t b, word_t w);
        exp_mem[b][exp_len[b]] = w;
        exp_len[b] = exp_len[b] + 1;
    endtask

    // ==========================================================
    // Checks
    // ==========================================================
    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "first error, run stopped");
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s is %h, expected %h",
                $time, name, got, exp));
        end
    endtask

    task automatic check_count(string name, word_count_t got, word_count_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s is %0d, expected %0d",
                $time, name, got, exp));
        end
    endtask

    task automatic check_stat(string name, stat_count_t got, stat_count_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s is %0d, expected %0d",
                $time, name, got, exp));
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s is %b, expected %b",
                $time, name, got, exp));
        end
    endtask

    // ==========================================================
    // Sensor and host drivers
    // ==========================================================
    task automatic drive_sensor(logic fv, logic lv, pixel_t d);
        @(negedge clk);
        pix_fv = fv;
        pix_lv = lv;
        pix_d  = d;
    endtask

    task automatic drive_idle(int lines, int width);
        repeat (lines * (width + line_blank)) begin
            drive_sensor(1'b0, 1'b0, '0);
        end
    endtask

    // req_row raises cmd_req at the start of that line
    task automatic drive_frame(int width, int height, bit keep, block_sel_t b, int req_row);
        pixel_t p;
        for (int r = 0; r < height; r++) begin
            if (r == req_row) begin
                cmd_req = 1'b1;
            end
            for (int c = 0; c < width; c++) begin
                p = next_pixel();
                drive_sensor(1'b1, 1'b1, p);
                if (keep) begin
                    store_word(b, word_t'(p));
                    // 4x4 sampling grid
                    if (c % 4 == 0 && r % 4 == 0) begin
                        if (&p[pixel_w-1 -: stat_bits]) begin
                            exp_highlight = exp_highlight + 1'b1;
                        end else if (p[pixel_w-1 -: stat_bits] == '0) begin
                            exp_shadow = exp_shadow + 1'b1;
                        end
                    end
                end
            end
            repeat (line_blank) begin
                drive_sensor(1'b1, 1'b0, '0);
            end
        end
        drive_sensor(1'b0, 1'b0, '0);
    endtask

    task automatic wait_ack(string what);
        int n;
        n = 0;
        while (cmd_ack !== 1'b1 && n < ack_timeout) begin
            @(negedge clk);
            n++;
        end
        if (cmd_ack !== 1'b1) begin
            stop_on_error({"Timed out waiting for cmd_ack after ", what});
        end
    endtask

    task automatic release_request();
        int n;
        n = 0;
        cmd_req = 1'b0;
        while (cmd_ack !== 1'b0 && n < ack_timeout) begin
            @(negedge clk);
            n++;
        end
        if (cmd_ack !== 1'b0) begin
            stop_on_error("cmd_ack stayed high after cmd_req was dropped");
        end
    endtask

    task automatic run_capture(frame_row_t f);
        header_t     hdr;
        word_t       hw;
        int          w;
        int          h;
        logic [31:0] sum;
        w = int'(f.width);
        h = int'(f.height);
        exp_len[f.blk] = 0;
        exp_highlight  = '0;
        exp_shadow     = '0;
        // Header word 0 carries the row seed
        hdr = '0;
        for (int i = 0; i < header_words; i++) begin
            hw  = (i == 0) ? f.seed : word_t'(lfsr_bits(word_w));
            hdr = {hdr[header_w-word_w-1:0], hw};
            store_word(f.blk, hw);
        end
        cmd_op     = CMD_CAPTURE;
        cmd_block  = f.blk;
        cmd_header = hdr;
        if (f.mid_frame) begin
            // A frame is already running when the command arrives
            drive_frame(w, 3, 1'b0, f.blk, 1);
        end else begin
            cmd_req = 1'b1;
        end
        drive_idle(int'(f.idle_lines), w);
        drive_frame(w, h, 1'b1, f.blk, -1);
        sum = fletcher32(f.blk, exp_len[f.blk]);
        store_word(f.blk, sum[31:16]);
        store_word(f.blk, sum[15:0]);
        wait_ack("capture");
        check_count("status_word_count", status_word_count,
            word_count_t'(header_words + w * h + 2));
        check_stat("status_highlight_count", status_highlight_count, exp_highlight);
        check_stat("status_shadow_count", status_shadow_count, exp_shadow);
        release_request();
    endtask

    task automatic run_readout(block_sel_t b, logic gaps);
        int   n;
        int   cycles;
        logic ready;
        logic done;
        n      = 0;
        cycles = 0;
        done   = 1'b0;
        cmd_op    = CMD_READOUT;
        cmd_block = b;
        cmd_req   = 1'b1;
        while (!done && cycles < readout_timeout) begin
            @(negedge clk);
            cycles++;
            if (cmd_ack === 1'b1) begin
                done = 1'b1;
            end else begin
                ready = gaps ? lfsr_step() : 1'b1;
                readout_ready = ready;
                // Transfer happens at the coming rising edge
                if (readout_valid && ready) begin
                    if (n >= exp_len[b]) begin
                        stop_on_error("Readout delivered more words than the block holds");
                    end
                    check_word("readout_data", readout_data, exp_mem[b][n]);
                    n++;
                end
            end
        end
        if (!done) begin
            stop_on_error("Timed out waiting for the readout to finish");
        end
        check_count("readout word count", word_count_t'(n), word_count_t'(exp_len[b]));
        readout_ready = 1'b1;
        release_request();
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================
    initial begin
        lfsr          = 32'h9d19e576;
        rst_n         = 1'b0;
        cmd_req       = 1'b0;
        cmd_op        = CMD_CAPTURE;
        cmd_block     = '0;
        cmd_header    = '0;
        pix_d         = '0;
        pix_fv        = 1'b0;
        pix_lv        = 1'b0;
        readout_ready = 1'b1;
        exp_len[0]    = 0;
        exp_len[1]    = 0;
        exp_highlight = '0;
        exp_shadow    = '0;

        //           blk   width  height idle  mid   gaps  seed
        frames[0] = '{1'b0, 8'd16, 8'd12, 4'd2, 1'b0, 1'b0, 16'hc0de};
        frames[1] = '{1'b1, 8'd12, 8'd9,  4'd3, 1'b1, 1'b1, 16'h5a17};
        frames[2] = '{1'b0, 8'd20, 8'd7,  4'd1, 1'b1, 1'b1, 16'h0b3e};
        frames[3] = '{1'b1, 8'd9,  8'd14, 4'd3, 1'b0, 1'b0, 16'h7e41};

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        check_flag("cmd_ack", cmd_ack, 1'b0);
        check_flag("readout_valid", readout_valid, 1'b0);
        // Blocks that were never written read back empty
        run_readout(1'b0, 1'b0);
        run_readout(1'b1, 1'b0);

        for (int i = 0; i < frame_rows; i++) begin
            run_capture(frames[i]);
            run_readout(frames[i].blk, 1'b0);
            if (frames[i].gaps) begin
                run_readout(frames[i].blk, 1'b1);
            end
            // Other block keeps its own image
            run_readout(block_sel_t'(~frames[i].blk), 1'b1);
        end

        run_readout(1'b1, 1'b0);
        run_readout(1'b0, 1'b1);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: compile.f
rtl/img_pkg.sv
rtl/ctrl_pkg.sv
rtl/fletcher_checksum.sv
rtl/pixel_capture.sv
rtl/image_ram.sv
rtl/word_fifo.sv
rtl/img_controller.sv
verification/img_controller_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the image controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module img_controller_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vimg_controller_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
echo "Pass message not found in simulator output"
exit 1
